//--- source/piarb_settings.svh
// piarb settings for bus width, address split, requester count and memory depth.
`ifndef PIARB_SETTINGS_SVH
`define PIARB_SETTINGS_SVH

// ====================
// host bus.
// ====================

// one word carries both the address and the data.
`define PIO_NBITS 16

// top address bits pick the target.
`define PIARB_REGION_NBITS 2

// ====================
// targets.
// ====================

// topic memory index width, 16 words.
`define PIARB_TOPIC_AW 4

// register index width inside the arbiter region.
`define PIARB_REG_AW 3

// requesters on the arbiter.
`define PIARB_NPORTS 4

// port index width, log2 of the port count.
`define PIARB_PORT_AW 2

// grant counter width. counters wrap.
`define PIARB_CNT_NBITS 16

`endif

//--- source/piarb_pkg.sv
// piarb shared types for address views, target regions and the arbiter register map.
`include "piarb_settings.svh"

package piarb_pkg;

	// ====================
	// target regions.
	// ====================
	typedef enum logic [`PIARB_REGION_NBITS-1:0] {
		REGION_TOPIC_VALUE = 2'd0,	// topic value memory.
		REGION_ARB         = 2'd1,	// arbiter registers.
		REGION_RSVD        = 2'd3	// reserved, answered by the decoder itself.
	} region_e;

	// arbiter register index.
	typedef enum logic [`PIARB_REG_AW-1:0] {
		ARB_ENABLE   = 3'd0,	// port enable mask, r/w.
		ARB_LAST_GNT = 3'd1,	// {valid, .., index}, ro.
		ARB_CNT0     = 3'd2,	// grant counters, ro.
		ARB_CNT1     = 3'd3,
		ARB_CNT2     = 3'd4,
		ARB_CNT3     = 3'd5
	} arb_reg_e;

	// ====================
	// address word views.
	// ====================
	typedef struct packed {
		region_e                                                     region;
		logic [`PIO_NBITS-`PIARB_REGION_NBITS-`PIARB_TOPIC_AW-1:0] pad;
		logic [`PIARB_TOPIC_AW-1:0]                                  index;
	} mem_addr_t;

	typedef struct packed {
		region_e                                                   region;
		logic [`PIO_NBITS-`PIARB_REGION_NBITS-`PIARB_REG_AW-1:0] pad;
		arb_reg_e                                                  index;
	} reg_addr_t;

	// same bits, memory target or register target.
	typedef union packed {
		mem_addr_t mem;
		reg_addr_t regs;
	} pio_addr_u;

endpackage

//--- source/piarb_slave_if.sv
// piarb target bus between the PIO decoder and one target.
`include "piarb_settings.svh"

interface piarb_slave_if;

	// ====================
	// decoder to target.
	// ====================
	logic                  ms;	// bus select and region match.
	logic                  wr;	// write strobe, one clk.
	logic                  rd;	// read strobe, one clk.
	piarb_pkg::pio_addr_u  addr;	// held until ack.
	logic [`PIO_NBITS-1:0] wdata;

	// ====================
	// target to decoder.
	// ====================
	logic                  ack;	// high until ms falls.
	logic [`PIO_NBITS-1:0] rdata;	// valid with ack.

	// decoder side.
	modport master (
		output ms, wr, rd, addr, wdata,
		input  ack, rdata
	);

	// target side.
	modport slave (
		input  ms, wr, rd, addr, wdata,
		output ack, rdata
	);

endinterface

//--- source/piarb_topic_mem.sv
// piarb topic value memory, 16 words read and written over the target bus.
`include "piarb_settings.svh"

module piarb_topic_mem (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         clk_div,	// bus tick.
	piarb_slave_if.slave bus
);

	// ====================
	// storage.
	// ====================
	logic [`PIO_NBITS-1:0] mem [2**`PIARB_TOPIC_AW];
	logic [`PIO_NBITS-1:0] rd_word;
	logic                  strobe;
	logic                  ack_tick;

	// any strobe of the current access.
	assign strobe = bus.wr | bus.rd;

	// first tick after the strobe, still selected.
	assign ack_tick = bus.ms & clk_div & ~strobe;

	// memory view of the address.
	assign rd_word = mem[bus.addr.mem.index];

	// write lands on the strobe edge.
	always_ff @(posedge clk) begin
		if (bus.ms && bus.wr) begin
			mem[bus.addr.mem.index] <= bus.wdata;
		end
	end

	// ====================
	// response.
	// ====================

	// ack holds until the decoder drops select.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus.ack <= 1'b0;
		end else if (!bus.ms) begin
			bus.ack <= 1'b0;	// access over.
		end else if (ack_tick) begin
			bus.ack <= 1'b1;
		end
	end

	// read word captured together with ack.
	always_ff @(posedge clk) begin
		if (ack_tick && !bus.ack) begin
			bus.rdata <= rd_word;	// write access just returns the stored word.
		end
	end

	// ====================
	// checks.
	// ====================

	// host gives one strobe kind per access.
	one_strobe: assert property (
		@(posedge clk) disable iff (!rst_n)
		bus.ms |-> !(bus.wr && bus.rd)
	);

endmodule

//--- source/piarb_rr_arb.sv
// piarb round-robin arbiter with enable mask, last grant and per-port grant counters.
`include "piarb_settings.svh"

module piarb_rr_arb (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     clk_div,	// bus tick.
	input  logic [`PIARB_NPORTS-1:0] req,
	piarb_slave_if.slave             bus,
	output logic [`PIARB_NPORTS-1:0] gnt,
	output logic                     gnt_valid
);

	// ====================
	// state.
	// ====================
	logic [`PIARB_NPORTS-1:0]    enable;
	logic [`PIARB_PORT_AW-1:0]   last_idx;
	logic                        last_valid;
	logic [`PIARB_CNT_NBITS-1:0] cnt [`PIARB_NPORTS];
	logic [`PIARB_NPORTS-1:0]    masked;
	logic [`PIARB_NPORTS-1:0]    nxt;
	logic [`PIARB_PORT_AW-1:0]   nxt_idx;
	logic                        found;
	logic                        strobe;
	logic                        ack_tick;
	logic [`PIO_NBITS-1:0]       rd_word;

	assign masked = req & enable;

	// search starts at the port after the last grant.
	always_comb begin
		int p;
		nxt     = '0;
		nxt_idx = '0;
		found   = 1'b0;
		for (int i = 1; i <= `PIARB_NPORTS; i++) begin
			p = (int'(last_idx) + i) % `PIARB_NPORTS;
			if (!found && masked[p]) begin
				nxt[p]  = 1'b1;
				nxt_idx = `PIARB_PORT_AW'(p);
				found   = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gnt        <= '0;
			gnt_valid  <= 1'b0;
			last_idx   <= `PIARB_PORT_AW'(`PIARB_NPORTS-1);
			last_valid <= 1'b0;
			for (int i = 0; i < `PIARB_NPORTS; i++) cnt[i] <= '0;
		end else begin
			gnt       <= nxt;
			gnt_valid <= found;
			if (found) begin
				last_idx     <= nxt_idx;
				last_valid   <= 1'b1;
				cnt[nxt_idx] <= cnt[nxt_idx] + 1'b1;
			end
		end
	end

	// ====================
	// registers.
	// ====================
	assign strobe   = bus.wr | bus.rd;
	assign ack_tick = bus.ms & clk_div & ~strobe;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable <= '1;
		end else if (bus.ms && bus.wr && bus.addr.regs.index == piarb_pkg::ARB_ENABLE) begin
			enable <= bus.wdata[`PIARB_NPORTS-1:0];
		end
	end

	always_comb begin
		rd_word = '0;
		case (bus.addr.regs.index)
			piarb_pkg::ARB_ENABLE:   rd_word[`PIARB_NPORTS-1:0] = enable;
			piarb_pkg::ARB_LAST_GNT: begin
				rd_word[`PIO_NBITS-1]        = last_valid;
				rd_word[`PIARB_PORT_AW-1:0]  = last_idx;
			end
			piarb_pkg::ARB_CNT0:     rd_word = `PIO_NBITS'(cnt[0]);
			piarb_pkg::ARB_CNT1:     rd_word = `PIO_NBITS'(cnt[1]);
			piarb_pkg::ARB_CNT2:     rd_word = `PIO_NBITS'(cnt[2]);
			piarb_pkg::ARB_CNT3:     rd_word = `PIO_NBITS'(cnt[3]);
			default:                 rd_word = '0;
		endcase
	end

	// ack holds until the decoder drops select.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus.ack <= 1'b0;
		end else if (!bus.ms) begin
			bus.ack <= 1'b0;
		end else if (ack_tick) begin
			bus.ack <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ack_tick && !bus.ack) begin
			bus.rdata <= rd_word;
		end
	end

	// ====================
	// checks.
	// ====================

	// at most one port granted, flagged by gnt_valid.
	gnt_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(gnt) && (gnt_valid == |gnt)
	);

endmodule

//--- source/piarb_pio.sv
// piarb PIO decoder, routes host accesses to one target and registers its reply.
`include "piarb_settings.svh"

module piarb_pio (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  clk_div,	// bus tick.
	input  logic                  reg_bs,	// bus select.
	input  logic                  reg_wr,
	input  logic                  reg_rd,
	input  logic [`PIO_NBITS-1:0] reg_addr,
	input  logic [`PIO_NBITS-1:0] reg_din,
	piarb_slave_if.master         topic_bus,
	piarb_slave_if.master         arb_bus,
	output logic                  pio_ack,
	output logic                  pio_rvalid,
	output logic [`PIO_NBITS-1:0] pio_rdata
);

	piarb_pkg::pio_addr_u  addr_w;
	logic                  reg_rd_d1;	// read seen, rvalid not shown yet.
	logic                  rd_en;
	logic                  n_ack;	// selected target reply.
	logic [`PIO_NBITS-1:0] n_rdata;
	logic                  none_sel;	// unmapped region selected.
	logic                  none_pend;	// first stage of none-selected ack.
	logic                  none_ack;	// second stage.

	assign addr_w = reg_addr;
	assign rd_en  = reg_rd | reg_rd_d1;

	// ====================
	// targets.
	// ====================

	// strobes and payload go to both, select to one.
	assign topic_bus.wr    = reg_wr;
	assign topic_bus.rd    = reg_rd;
	assign topic_bus.addr  = addr_w;
	assign topic_bus.wdata = reg_din;
	assign arb_bus.wr      = reg_wr;
	assign arb_bus.rd      = reg_rd;
	assign arb_bus.addr    = addr_w;
	assign arb_bus.wdata   = reg_din;

	always_comb begin
		topic_bus.ms = 1'b0;
		arb_bus.ms   = 1'b0;
		none_sel     = 1'b0;
		n_ack        = 1'b0;
		n_rdata      = '0;	// unmapped reads give zero.
		case (addr_w.mem.region)
			piarb_pkg::REGION_TOPIC_VALUE: begin
				topic_bus.ms = reg_bs;
				n_ack        = reg_bs & topic_bus.ack;
				n_rdata      = topic_bus.rdata;
			end
			piarb_pkg::REGION_ARB: begin
				arb_bus.ms = reg_bs;
				n_ack      = reg_bs & arb_bus.ack;
				n_rdata    = arb_bus.rdata;
			end
			default: begin
				none_sel = reg_bs;
				n_ack    = reg_bs & none_ack;
			end
		endcase
	end

	// ====================
	// host reply.
	// ====================

	// reads show rvalid first, ack only once rd_en clears.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pio_ack    <= 1'b0;
			pio_rvalid <= 1'b0;
		end else if (clk_div) begin
			pio_ack    <= n_ack & ~rd_en;
			pio_rvalid <= reg_bs & rd_en & n_ack;
		end
	end

	// data follows the selected target each tick.
	always_ff @(posedge clk) begin
		if (clk_div) begin
			pio_rdata <= n_rdata;
		end
	end

	// delayed read flag, dropped once rvalid is out.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_rd_d1 <= 1'b0;
		end else if (reg_rd) begin
			reg_rd_d1 <= reg_bs;
		end else if (pio_rvalid) begin
			reg_rd_d1 <= 1'b0;
		end
	end

	// unmapped region answers like a target, one tick behind the strobe.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			none_pend <= 1'b0;
			none_ack  <= 1'b0;
		end else if (!reg_bs) begin
			none_pend <= 1'b0;
			none_ack  <= 1'b0;
		end else begin
			if ((reg_wr | reg_rd) & none_sel) begin
				none_pend <= 1'b1;
			end
			if (clk_div) begin
				none_ack <= none_pend;
			end
		end
	end

	// rvalid and ack are separate ticks of a read.
	ack_rvalid_apart: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(pio_ack && pio_rvalid)
	);

endmodule

//--- source/piarb_top.sv
// piarb top level, PIO decoder with topic memory and round-robin arbiter targets.
`include "piarb_settings.svh"

module piarb_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     clk_div,	// bus tick enable.

	// ====================
	// host PIO bus.
	// ====================
	input  logic                     reg_bs,
	input  logic                     reg_wr,
	input  logic                     reg_rd,
	input  logic [`PIO_NBITS-1:0]    reg_addr,
	input  logic [`PIO_NBITS-1:0]    reg_din,
	output logic                     pio_ack,
	output logic                     pio_rvalid,
	output logic [`PIO_NBITS-1:0]    pio_rdata,

	// ====================
	// requesters.
	// ====================
	input  logic [`PIARB_NPORTS-1:0] req,	// level request per port.
	output logic [`PIARB_NPORTS-1:0] gnt,	// one-hot.
	output logic                     gnt_valid
);

	// one bus per target.
	piarb_slave_if topic_bus ();
	piarb_slave_if arb_bus ();

	// address decode and reply path.
	piarb_pio u_pio (
		.clk        (clk),
		.rst_n      (rst_n),
		.clk_div    (clk_div),
		.reg_bs     (reg_bs),
		.reg_wr     (reg_wr),
		.reg_rd     (reg_rd),
		.reg_addr   (reg_addr),
		.reg_din    (reg_din),
		.topic_bus  (topic_bus),
		.arb_bus    (arb_bus),
		.pio_ack    (pio_ack),
		.pio_rvalid (pio_rvalid),
		.pio_rdata  (pio_rdata)
	);

	piarb_topic_mem u_topic_mem (
		.clk     (clk),
		.rst_n   (rst_n),
		.clk_div (clk_div),
		.bus     (topic_bus)
	);

	piarb_rr_arb u_rr_arb (
		.clk       (clk),
		.rst_n     (rst_n),
		.clk_div   (clk_div),
		.req       (req),
		.bus       (arb_bus),
		.gnt       (gnt),
		.gnt_valid (gnt_valid)
	);

endmodule

//--- test/piarb_tb.sv
// piarb testbench, table-driven host bus accesses with round-robin grant checks.
`include "piarb_settings.svh"

module piarb_tb;

	// ====================
	// constants.
	// ====================
	localparam int NB = `PIO_NBITS;
	localparam int NP = `PIARB_NPORTS;
	localparam int RB = `PIARB_REGION_NBITS;

	localparam logic [RB-1:0] RG_TOPIC = 2'd0;	// topic memory.
	localparam logic [RB-1:0] RG_ARB   = 2'd1;	// arbiter registers.
	localparam logic [RB-1:0] RG_RSVD  = 2'd3;	// unmapped.

	localparam int R_ENABLE = 0;
	localparam int R_LAST   = 1;
	localparam int R_CNT0   = 2;

	// row kinds.
	localparam int OP_WR       = 0;
	localparam int OP_RD       = 1;
	localparam int OP_RD_CNT   = 2;	// expected from grant model.
	localparam int OP_RD_LAST  = 3;
	localparam int OP_ARB_HOLD = 4;	// requests held for data cycles.
	localparam int OP_ARB_ONCE = 5;	// each requester drops after its grant.

	// ====================
	// DUT signals.
	// ====================
	logic          clk = 1'b0;
	logic          rst_n;
	logic          clk_div;
	logic          reg_bs;
	logic          reg_wr;
	logic          reg_rd;
	logic [NB-1:0] reg_addr;
	logic [NB-1:0] reg_din;
	logic [NP-1:0] req;
	logic          pio_ack;
	logic          pio_rvalid;
	logic [NB-1:0] pio_rdata;
	logic [NP-1:0] gnt;
	logic          gnt_valid;

	// stimulus table, one entry per row.
	int            row_op[$];
	string         row_name[$];
	logic [NB-1:0] row_addr[$];
	logic [NB-1:0] row_data[$];
	logic [NP-1:0] row_req[$];
	logic [NB-1:0] row_exp[$];

	// reference state.
	logic [NB-1:0] mem_copy [16];
	logic [NP-1:0] mask_model;	// enable mask as written.
	int            last_model;	// last granted port.
	int            gnt_count [NP];
	int            div_cnt;
	bit            table_ready;

	piarb_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.clk_div    (clk_div),
		.reg_bs     (reg_bs),
		.reg_wr     (reg_wr),
		.reg_rd     (reg_rd),
		.reg_addr   (reg_addr),
		.reg_din    (reg_din),
		.pio_ack    (pio_ack),
		.pio_rvalid (pio_rvalid),
		.pio_rdata  (pio_rdata),
		.req        (req),
		.gnt        (gnt),
		.gnt_valid  (gnt_valid)
	);

	always #5 clk = ~clk;

	// bus tick, one clk in three.
	always @(negedge clk) begin
		div_cnt = (div_cnt + 1) % 3;
		clk_div = (div_cnt == 0);
	end

	// ====================
	// helpers.
	// ====================

	// region in the top bits, index in the low bits.
	function automatic logic [NB-1:0] make_addr(input logic [RB-1:0] region, input int idx);
		logic [NB-1:0] a;
		a = '0;
		a[NB-1 -: RB] = region;
		a[3:0] = 4'(idx);
		return a;
	endfunction

	// search starts at the port after the last grant.
	function automatic logic [NP-1:0] rr_pick(input logic [NP-1:0] reqs, input int last);
		int p;
		for (int i = 1; i <= NP; i++) begin
			p = (last + i) % NP;
			if (reqs[p]) begin
				return NP'(1) << p;
			end
		end
		return '0;	// nothing enabled and pending.
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
			$display("Some tests failed");
			$fatal(1, "check failed at time %0t", $time);
		end
	endtask

	task automatic add_row(input int op, input string name, input logic [NB-1:0] addr,
		input logic [NB-1:0] data, input logic [NP-1:0] reqs, input logic [NB-1:0] exp);
		row_op.push_back(op);
		row_name.push_back(name);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_req.push_back(reqs);
		row_exp.push_back(exp);
	endtask

	// one host access, called and returning on a falling edge.
	task automatic bus_access(input string name, input logic is_rd, input logic [NB-1:0] addr,
		input logic [NB-1:0] din, output logic [NB-1:0] rdata);
		int            rv_count;
		logic          rv_prev;
		logic [NB-1:0] captured;
		rv_count = 0;
		rv_prev  = 1'b0;
		captured = '0;
		@(negedge clk);
		reg_bs   = 1'b1;
		reg_wr   = ~is_rd;
		reg_rd   = is_rd;
		reg_addr = addr;
		reg_din  = din;
		@(negedge clk);
		reg_wr = 1'b0;	// strobe is one clk.
		reg_rd = 1'b0;
		while (!pio_ack) begin
			if (pio_rvalid && !rv_prev) begin
				rv_count++;
				captured = pio_rdata;	// data shown with rvalid.
			end
			rv_prev = pio_rvalid;
			@(negedge clk);
		end
		check_value({name, " rvalid count"}, 32'(is_rd), 32'(rv_count));
		reg_bs = 1'b0;
		// ack holds until the next tick sees select low.
		while (pio_ack) begin
			@(negedge clk);
		end
		repeat (int'($urandom_range(3, 1))) @(negedge clk);
		rdata = captured;
	endtask

	// drive one request vector, check the grant a cycle later.
	task automatic arb_step(input string name, input logic [NP-1:0] reqs,
		output logic [NP-1:0] got);
		logic [NP-1:0] exp;
		req = reqs;
		exp = rr_pick(reqs & mask_model, last_model);
		@(negedge clk);
		check_value({name, " gnt"}, 32'(exp), 32'(gnt));
		check_value({name, " gnt_valid"}, 32'(|exp), 32'(gnt_valid));
		for (int p = 0; p < NP; p++) begin
			if (exp[p]) begin
				last_model = p;
				gnt_count[p]++;
			end
		end
		got = gnt;
	endtask

	// ====================
	// table.
	// ====================
	task automatic build_table();
		int order [16];
		int j;
		int tmp;
		for (int i = 0; i < 16; i++) begin
			mem_copy[i] = NB'($urandom);
			add_row(OP_WR, $sformatf("topic write %0d", i), make_addr(RG_TOPIC, i),
				mem_copy[i], '0, '0);
			order[i] = i;
		end
		// shuffled read-back order.
		for (int i = 15; i > 0; i--) begin
			j = int'($urandom_range(i, 0));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < 16; i++) begin
			add_row(OP_RD, $sformatf("topic read %0d", order[i]),
				make_addr(RG_TOPIC, order[i]), '0, '0, mem_copy[order[i]]);
		end
		// unmapped region, must touch neither target.
		// low bits clear, unlike the reset mask.
		add_row(OP_WR, "reserved write", make_addr(RG_RSVD, 0), ~mem_copy[0] & ~NB'(4'hf),
			'0, '0);
		add_row(OP_RD, "reserved read", make_addr(RG_RSVD, 5), '0, '0, '0);
		add_row(OP_RD, "topic 0 after reserved write", make_addr(RG_TOPIC, 0), '0, '0,
			mem_copy[0]);
		add_row(OP_RD, "enable after reserved write", make_addr(RG_ARB, R_ENABLE), '0, '0,
			NB'(4'b1111));
		// round robin, all held then ports 1 and 3.
		add_row(OP_ARB_HOLD, "all ports held", '0, NB'(5), 4'b1111, '0);
		add_row(OP_ARB_HOLD, "ports 1 and 3 held", '0, NB'(4), 4'b1010, '0);
		// port 2 masked off.
		add_row(OP_WR, "enable write", make_addr(RG_ARB, R_ENABLE), NB'(4'b1011), '0, '0);
		add_row(OP_RD, "enable read back", make_addr(RG_ARB, R_ENABLE), '0, '0, NB'(4'b1011));
		add_row(OP_ARB_ONCE, "masked requests", '0, '0, 4'b1111, '0);
		for (int p = 0; p < NP; p++) begin
			add_row(OP_RD_CNT, $sformatf("grant counter %0d", p), make_addr(RG_ARB, R_CNT0 + p),
				NB'(p), '0, '0);
		end
		add_row(OP_RD_LAST, "last grant", make_addr(RG_ARB, R_LAST), '0, '0, '0);
	endtask

	task automatic apply_row(input int i);
		logic [NB-1:0] rd;
		logic [NP-1:0] got;
		logic [NP-1:0] pending;
		case (row_op[i])
			OP_WR: begin
				bus_access(row_name[i], 1'b0, row_addr[i], row_data[i], rd);
				if (row_addr[i] == make_addr(RG_ARB, R_ENABLE)) begin
					mask_model = row_data[i][NP-1:0];
				end
			end
			OP_RD: begin
				bus_access(row_name[i], 1'b1, row_addr[i], '0, rd);
				check_value(row_name[i], 32'(row_exp[i]), 32'(rd));
			end
			OP_RD_CNT: begin
				bus_access(row_name[i], 1'b1, row_addr[i], '0, rd);
				check_value(row_name[i], gnt_count[int'(row_data[i])] % (1 << `PIARB_CNT_NBITS),
					32'(rd));	// counters wrap.
			end
			OP_RD_LAST: begin
				bus_access(row_name[i], 1'b1, row_addr[i], '0, rd);
				check_value({row_name[i], " index"}, last_model, 32'(rd[`PIARB_PORT_AW-1:0]));
				check_value({row_name[i], " valid"}, 32'd1, 32'(rd[NB-1]));
			end
			OP_ARB_HOLD: begin
				repeat (row_data[i]) arb_step(row_name[i], row_req[i], got);
				arb_step({row_name[i], " idle"}, '0, got);
			end
			OP_ARB_ONCE: begin
				pending = row_req[i];
				while ((pending & mask_model) != '0) begin
					arb_step(row_name[i], pending, got);
					pending = pending & ~got;	// drop after own grant.
				end
				// masked ports still requesting on their own.
				arb_step({row_name[i], " masked only"}, pending, got);
				arb_step({row_name[i], " idle"}, '0, got);
			end
			default: begin
				$display("Table row %0d holds an unknown operation", i);
				$display("Some tests failed");
				$fatal(1, "bad table row");
			end
		endcase
	endtask

	// ====================
	// run.
	// ====================
	initial begin
		void'($urandom(32'h4b881e80));
		rst_n    = 1'b0;
		clk_div  = 1'b0;
		div_cnt  = 0;
		reg_bs   = 1'b0;
		reg_wr   = 1'b0;
		reg_rd   = 1'b0;
		reg_addr = '0;
		reg_din  = '0;
		req      = '0;
		mask_model = '1;	// reset mask, all ports.
		last_model = NP - 1;	// first search starts at port 0.
		for (int p = 0; p < NP; p++) begin
			gnt_count[p] = 0;
		end
		build_table();
		table_ready = 1'b1;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		for (int i = 0; i < row_op.size(); i++) begin
			apply_row(i);
		end
		$display("All tests passed");
		$finish;
	end

	// watchdog, 40 cycles per table row.
	initial begin
		wait (table_ready);
		repeat (row_op.size() * 40) @(posedge clk);
		$display("Timeout, the bus or the arbiter stopped responding");
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- project.f
+incdir+source
source/piarb_pkg.sv
source/piarb_slave_if.sv
source/piarb_topic_mem.sv
source/piarb_rr_arb.sv
source/piarb_pio.sv
source/piarb_top.sv
test/piarb_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := piarb_tb
FILELIST   := project.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
BIN        := $(OBJ_DIR)/V$(TOP)
SOURCES    := $(wildcard source/*.sv source/*.svh test/*.sv)

.PHONY: all build run lint clean

# build and run, exit status carries pass or fail.
all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
